// File: Bender.yml
package:
  name: tex_unit

sources:
  - rtl/tex_pkg.sv
  - rtl/tex_wrap.sv
  - rtl/tex_addr_gen.sv
  - rtl/tex_mem_sched.sv
  - rtl/tex_sampler.sv
  - rtl/tex_ctrl.sv
  - rtl/tex_unit_top.sv
  - target: test
    files:
      - test/tex_unit_chk.sv
      - test/tex_unit_tb.sv

// File: rtl/tex_addr_gen.sv
`timescale 1ns/1ps

module tex_addr_gen (
    input  logic              clk_i,
    input  logic              rst_n_i,
    input  tex_pkg::tex_cfg_t cfg_i,

    input  logic              req_valid_i,
    input  tex_pkg::tex_req_t req_i,
    output logic              req_ready_o,

    output logic              fp_valid_o,
    output tex_pkg::tex_fp_t  fp_o,
    input  logic              fp_ready_i
);
    import tex_pkg::*;

    logic [31:0]                                half_u;
    logic [31:0]                                half_v;
    logic [NUM_LANES-1:0][1:0][FIXED_FRAC-1:0] u_wr;   // index 0 is the minus offset
    logic [NUM_LANES-1:0][1:0][FIXED_FRAC-1:0] v_wr;
    tex_fp_t                                    fp_d;
    logic                                       stall;

    function automatic logic [ADDR_W-1:0] texel_addr(input tex_cfg_t cfg,
                                                     input logic [FIXED_FRAC-1:0] x,
                                                     input logic [FIXED_FRAC-1:0] y);
        logic [31:0] lin;
        lin = (32'(x) + (32'(y) << cfg.log2_w)) << cfg.log2_stride;
        return cfg.base + lin[ADDR_W-1:0];
    endfunction

    // half a texel in each axis, only used when filtering
    assign half_u = (cfg_i.filter == FILTER_BILINEAR) ? (FIXED_HALF >> cfg_i.log2_w) : '0;
    assign half_v = (cfg_i.filter == FILTER_BILINEAR) ? (FIXED_HALF >> cfg_i.log2_h) : '0;

    for (genvar l = 0; l < NUM_LANES; l++) begin : g_lane
        logic [1:0][31:0] cu;
        logic [1:0][31:0] cv;

        assign cu[0] = req_i.u[l] - half_u;
        assign cu[1] = req_i.u[l] + half_u;
        assign cv[0] = req_i.v[l] - half_v;
        assign cv[1] = req_i.v[l] + half_v;

        for (genvar k = 0; k < 2; k++) begin : g_ofs
            tex_wrap tex_wrap_u (
                .wrap_i  (cfg_i.wrap_u),
                .coord_i (cu[k]),
                .coord_o (u_wr[l][k])
            );

            tex_wrap tex_wrap_v (
                .wrap_i  (cfg_i.wrap_v),
                .coord_i (cv[k]),
                .coord_o (v_wr[l][k])
            );
        end
    end

    always_comb begin : p_addr
        logic [FIXED_FRAC-1:0] x0, x1, y0, y1;
        logic [FIXED_FRAC-1:0] fu, fv;

        fp_d.mask   = req_i.mask;
        fp_d.tag    = req_i.tag;
        fp_d.filter = cfg_i.filter;
        for (int l = 0; l < NUM_LANES; l++) begin
            x0 = u_wr[l][0] >> (FIXED_FRAC - cfg_i.log2_w);
            x1 = u_wr[l][1] >> (FIXED_FRAC - cfg_i.log2_w);
            y0 = v_wr[l][0] >> (FIXED_FRAC - cfg_i.log2_h);
            y1 = v_wr[l][1] >> (FIXED_FRAC - cfg_i.log2_h);
            fp_d.addr[l][0] = texel_addr(cfg_i, x0, y0);
            fp_d.addr[l][1] = texel_addr(cfg_i, x1, y0);
            fp_d.addr[l][2] = texel_addr(cfg_i, x0, y1);
            fp_d.addr[l][3] = texel_addr(cfg_i, x1, y1);
            // bits left below the texel index, aligned to the top
            fu = u_wr[l][0] << cfg_i.log2_w;
            fv = v_wr[l][0] << cfg_i.log2_h;
            fp_d.wu[l] = fu[FIXED_FRAC-1 -: WEIGHT_W];
            fp_d.wv[l] = fv[FIXED_FRAC-1 -: WEIGHT_W];
        end
    end

    assign stall       = fp_valid_o && !fp_ready_i;
    assign req_ready_o = !stall;

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            fp_valid_o <= 1'b0;
        end else if (!stall) begin
            fp_valid_o <= req_valid_i;
        end
    end

    always_ff @(posedge clk_i) begin
        if (!stall) begin
            fp_o <= fp_d;
        end
    end

endmodule

// File: rtl/tex_ctrl.sv
`timescale 1ns/1ps

module tex_ctrl (
    input  logic              clk_i,
    input  logic              rst_n_i,

    input  logic              cfg_we_i,
    input  tex_pkg::tex_cfg_e cfg_sel_i,
    input  logic [31:0]       cfg_data_i,
    output tex_pkg::tex_cfg_t cfg_o,

    input  logic              req_valid_i,
    output logic              req_ready_o,
    output logic              gen_valid_o,
    input  logic              gen_ready_i,
    input  logic              rsp_fire_i
);
    import tex_pkg::*;

    logic [INFLIGHT_W-1:0] inflight_q, inflight_d;
    logic                  room_q;   // in-flight count below the limit
    logic                  open;
    logic                  req_fire;

    // a config write in the same cycle would change cfg under the request
    assign open        = room_q && !cfg_we_i;
    assign gen_valid_o = req_valid_i && open;
    assign req_ready_o = gen_ready_i && open;
    assign req_fire    = req_valid_i && req_ready_o;

    assign inflight_d = inflight_q + INFLIGHT_W'(req_fire) - INFLIGHT_W'(rsp_fire_i);

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            inflight_q <= '0;
            room_q     <= 1'b0;
        end else begin
            inflight_q <= inflight_d;
            room_q     <= (inflight_d < INFLIGHT_W'(MAX_INFLIGHT));
        end
    end

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            cfg_o <= '0;
        end else if (cfg_we_i) begin
            case (cfg_sel_i)
                CFG_BASE: cfg_o.base <= cfg_data_i[ADDR_W-1:0];
                CFG_DIMS: begin
                    cfg_o.log2_w      <= cfg_data_i[LOG2_W-1:0];
                    cfg_o.log2_h      <= cfg_data_i[2*LOG2_W-1:LOG2_W];
                    cfg_o.log2_stride <= cfg_data_i[3*LOG2_W-1:2*LOG2_W];
                end
                CFG_MODE: begin
                    cfg_o.wrap_u <= tex_wrap_e'(cfg_data_i[1:0]);
                    cfg_o.wrap_v <= tex_wrap_e'(cfg_data_i[3:2]);
                    cfg_o.filter <= tex_filter_e'(cfg_data_i[4]);
                end
                default: ;   // unused selector is ignored
            endcase
        end
    end

endmodule

// File: rtl/tex_mem_sched.sv
`timescale 1ns/1ps

module tex_mem_sched (
    input  logic                       clk_i,
    input  logic                       rst_n_i,

    input  logic                       fp_valid_i,
    input  tex_pkg::tex_fp_t           fp_i,
    output logic                       fp_ready_o,

    output logic                       mem_rd_o,
    output logic [tex_pkg::ADDR_W-1:0] mem_addr_o,
    input  logic [31:0]                mem_data_i,

    output logic                       tx_valid_o,
    output tex_pkg::tex_tx_t           tx_o,
    input  logic                       tx_ready_i
);
    import tex_pkg::*;

    tex_sched_state_e                          state_q, state_d;
    tex_fp_t                                   fp_q;
    logic [NUM_LANES-1:0][FP_TEXELS-1:0][31:0] tex_q;
    logic [LANE_W-1:0]                         lane_q, rd_lane_q;
    logic [1:0]                                texel_q, rd_texel_q;
    logic                                      rd_pend_q;
    logic                                      fp_accept;
    logic                                      last_texel;
    logic [LANE_W:0]                           first_lane;
    logic [LANE_W:0]                           next_lane;

    // lowest active lane above 'after', with a found flag on top
    function automatic logic [LANE_W:0] find_lane(input logic [NUM_LANES-1:0] mask,
                                                  input int after);
        logic [LANE_W:0] res;
        res = '0;
        for (int i = NUM_LANES - 1; i >= 0; i--) begin
            if (mask[i] && (i > after)) res = {1'b1, i[LANE_W-1:0]};
        end
        return res;
    endfunction

    assign fp_ready_o = (state_q == SCHED_IDLE) && (!tx_valid_o || tx_ready_i);
    assign fp_accept  = fp_valid_i && fp_ready_o;
    assign first_lane = find_lane(fp_i.mask, -1);
    assign next_lane  = find_lane(fp_q.mask, int'(lane_q));
    assign last_texel = (fp_q.filter == FILTER_POINT) || (texel_q == 2'd3);

    assign mem_rd_o   = (state_q == SCHED_ISSUE);
    assign mem_addr_o = fp_q.addr[lane_q][texel_q];

    always_comb begin
        state_d = state_q;
        case (state_q)
            SCHED_IDLE:  if (fp_accept) state_d = first_lane[LANE_W] ? SCHED_ISSUE : SCHED_DRAIN;
            SCHED_ISSUE: if (last_texel && !next_lane[LANE_W]) state_d = SCHED_DRAIN;
            default:     state_d = SCHED_IDLE;   // last word lands during drain
        endcase
    end

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            state_q    <= SCHED_IDLE;
            rd_pend_q  <= 1'b0;
            tx_valid_o <= 1'b0;
        end else begin
            state_q   <= state_d;
            rd_pend_q <= mem_rd_o;
            if (state_q == SCHED_DRAIN) begin
                tx_valid_o <= 1'b1;
            end else if (tx_ready_i) begin
                tx_valid_o <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk_i) begin
        if (fp_accept) begin
            fp_q    <= fp_i;
            lane_q  <= first_lane[LANE_W-1:0];
            texel_q <= '0;
        end else if (state_q == SCHED_ISSUE) begin
            if (last_texel) begin
                lane_q  <= next_lane[LANE_W-1:0];
                texel_q <= '0;
            end else begin
                texel_q <= texel_q + 2'd1;
            end
        end
        rd_lane_q  <= lane_q;   // slot of the read in flight
        rd_texel_q <= texel_q;
        if (rd_pend_q) begin
            tex_q[rd_lane_q][rd_texel_q] <= mem_data_i;
        end
    end

    always_comb begin
        tx_o.mask   = fp_q.mask;
        tx_o.tag    = fp_q.tag;
        tx_o.filter = fp_q.filter;
        tx_o.texel  = tex_q;
        tx_o.wu     = fp_q.wu;
        tx_o.wv     = fp_q.wv;
    end

endmodule

// File: rtl/tex_pkg.sv
package tex_pkg;

    localparam int NUM_LANES    = 4;
    localparam int LANE_W       = $clog2(NUM_LANES);
    localparam int FP_TEXELS    = 4;   // bilinear footprint is a 2x2 quad
    localparam int FIXED_FRAC   = 20;
    localparam logic [31:0] FIXED_HALF = 32'h1 << (FIXED_FRAC - 1);
    localparam int TAG_W        = 4;
    localparam int ADDR_W       = 16;
    localparam int LOG2_W       = 4;
    localparam int WEIGHT_W     = 8;
    localparam int MAX_INFLIGHT = 4;
    localparam int INFLIGHT_W   = $clog2(MAX_INFLIGHT + 1);

    typedef enum logic [1:0] {
        WRAP_CLAMP,
        WRAP_REPEAT,
        WRAP_MIRROR
    } tex_wrap_e;

    typedef enum logic {
        FILTER_POINT,
        FILTER_BILINEAR
    } tex_filter_e;

    // CFG_DIMS data is {stride, height, width} in LOG2_W fields from bit 0,
    // CFG_MODE data is {filter, wrap_v, wrap_u} from bit 0
    typedef enum logic [1:0] {
        CFG_BASE,
        CFG_DIMS,
        CFG_MODE
    } tex_cfg_e;

    typedef enum logic [1:0] {
        SCHED_IDLE,
        SCHED_ISSUE,
        SCHED_DRAIN
    } tex_sched_state_e;

    typedef struct packed {
        logic [ADDR_W-1:0] base;
        logic [LOG2_W-1:0] log2_w;
        logic [LOG2_W-1:0] log2_h;
        logic [LOG2_W-1:0] log2_stride;
        tex_wrap_e         wrap_u;
        tex_wrap_e         wrap_v;
        tex_filter_e       filter;
    } tex_cfg_t;

    typedef struct packed {
        logic [NUM_LANES-1:0]       mask;
        logic [TAG_W-1:0]           tag;
        logic [NUM_LANES-1:0][31:0] u;
        logic [NUM_LANES-1:0][31:0] v;
    } tex_req_t;

    typedef struct packed {
        logic [NUM_LANES-1:0]                         mask;
        logic [TAG_W-1:0]                             tag;
        tex_filter_e                                  filter;
        logic [NUM_LANES-1:0][FP_TEXELS-1:0][ADDR_W-1:0] addr;
        logic [NUM_LANES-1:0][WEIGHT_W-1:0]           wu;
        logic [NUM_LANES-1:0][WEIGHT_W-1:0]           wv;
    } tex_fp_t;

    // same footprint with the fetched words in place of the addresses
    typedef struct packed {
        logic [NUM_LANES-1:0]                         mask;
        logic [TAG_W-1:0]                             tag;
        tex_filter_e                                  filter;
        logic [NUM_LANES-1:0][FP_TEXELS-1:0][31:0]    texel;
        logic [NUM_LANES-1:0][WEIGHT_W-1:0]           wu;
        logic [NUM_LANES-1:0][WEIGHT_W-1:0]           wv;
    } tex_tx_t;

    typedef struct packed {
        logic [NUM_LANES-1:0]       mask;
        logic [TAG_W-1:0]           tag;
        logic [NUM_LANES-1:0][31:0] texel;
    } tex_rsp_t;

endpackage

// File: rtl/tex_sampler.sv
`timescale 1ns/1ps

module tex_sampler (
    input  logic              clk_i,
    input  logic              rst_n_i,

    input  logic              tx_valid_i,
    input  tex_pkg::tex_tx_t  tx_i,
    output logic              tx_ready_o,

    output logic              rsp_valid_o,
    output tex_pkg::tex_rsp_t rsp_o,
    input  logic              rsp_ready_i
);
    import tex_pkg::*;

    tex_rsp_t rsp_d;

    function automatic logic [7:0] lerp(input logic [7:0] a,
                                        input logic [7:0] b,
                                        input logic [WEIGHT_W-1:0] w);
        logic [15:0] acc;
        acc = a * (16'd256 - w) + b * w;   // never above 255 * 256
        return acc[15:8];
    endfunction

    always_comb begin : p_blend
        logic [31:0] c00, c10, c01, c11;
        logic [31:0] mix;
        logic [7:0]  row0, row1;

        rsp_d.mask = tx_i.mask;
        rsp_d.tag  = tx_i.tag;
        for (int l = 0; l < NUM_LANES; l++) begin
            c00 = tx_i.texel[l][0];
            c10 = tx_i.texel[l][1];
            c01 = tx_i.texel[l][2];
            c11 = tx_i.texel[l][3];
            for (int ch = 0; ch < 4; ch++) begin
                row0 = lerp(c00[ch*8 +: 8], c10[ch*8 +: 8], tx_i.wu[l]);
                row1 = lerp(c01[ch*8 +: 8], c11[ch*8 +: 8], tx_i.wu[l]);
                mix[ch*8 +: 8] = lerp(row0, row1, tx_i.wv[l]);
            end
            if (!tx_i.mask[l]) begin
                rsp_d.texel[l] = '0;
            end else if (tx_i.filter == FILTER_POINT) begin
                rsp_d.texel[l] = c00;   // only the first texel was fetched
            end else begin
                rsp_d.texel[l] = mix;
            end
        end
    end

    assign tx_ready_o = !rsp_valid_o || rsp_ready_i;

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            rsp_valid_o <= 1'b0;
        end else if (tx_ready_o) begin
            rsp_valid_o <= tx_valid_i;
        end
    end

    always_ff @(posedge clk_i) begin
        if (tx_valid_i && tx_ready_o) begin
            rsp_o <= rsp_d;
        end
    end

endmodule

// File: rtl/tex_unit_top.sv
`timescale 1ns/1ps

module tex_unit_top (
    input  logic                       clk_i,
    input  logic                       rst_n_i,

    input  logic                       cfg_we_i,
    input  tex_pkg::tex_cfg_e          cfg_sel_i,
    input  logic [31:0]                cfg_data_i,

    input  logic                       req_valid_i,
    output logic                       req_ready_o,
    input  tex_pkg::tex_req_t          req_i,

    output logic                       mem_rd_o,
    output logic [tex_pkg::ADDR_W-1:0] mem_addr_o,
    input  logic [31:0]                mem_data_i,

    output logic                       rsp_valid_o,
    input  logic                       rsp_ready_i,
    output tex_pkg::tex_rsp_t          rsp_o
);
    import tex_pkg::*;

    tex_cfg_t cfg;
    logic     gen_valid, gen_ready;
    logic     fp_valid, fp_ready;
    tex_fp_t  fp;
    logic     tx_valid, tx_ready;
    tex_tx_t  tx;

    tex_ctrl tex_ctrl_i (
        .clk_i       (clk_i),
        .rst_n_i     (rst_n_i),
        .cfg_we_i    (cfg_we_i),
        .cfg_sel_i   (cfg_sel_i),
        .cfg_data_i  (cfg_data_i),
        .cfg_o       (cfg),
        .req_valid_i (req_valid_i),
        .req_ready_o (req_ready_o),
        .gen_valid_o (gen_valid),
        .gen_ready_i (gen_ready),
        .rsp_fire_i  (rsp_valid_o && rsp_ready_i)
    );

    tex_addr_gen tex_addr_gen_i (
        .clk_i       (clk_i),
        .rst_n_i     (rst_n_i),
        .cfg_i       (cfg),
        .req_valid_i (gen_valid),
        .req_i       (req_i),
        .req_ready_o (gen_ready),
        .fp_valid_o  (fp_valid),
        .fp_o        (fp),
        .fp_ready_i  (fp_ready)
    );

    tex_mem_sched tex_mem_sched_i (
        .clk_i      (clk_i),
        .rst_n_i    (rst_n_i),
        .fp_valid_i (fp_valid),
        .fp_i       (fp),
        .fp_ready_o (fp_ready),
        .mem_rd_o   (mem_rd_o),
        .mem_addr_o (mem_addr_o),
        .mem_data_i (mem_data_i),
        .tx_valid_o (tx_valid),
        .tx_o       (tx),
        .tx_ready_i (tx_ready)
    );

    tex_sampler tex_sampler_i (
        .clk_i       (clk_i),
        .rst_n_i     (rst_n_i),
        .tx_valid_i  (tx_valid),
        .tx_i        (tx),
        .tx_ready_o  (tx_ready),
        .rsp_valid_o (rsp_valid_o),
        .rsp_o       (rsp_o),
        .rsp_ready_i (rsp_ready_i)
    );

endmodule

// File: rtl/tex_wrap.sv
`timescale 1ns/1ps

module tex_wrap (
    input  tex_pkg::tex_wrap_e             wrap_i,
    input  logic [31:0]                    coord_i,
    output logic [tex_pkg::FIXED_FRAC-1:0] coord_o
);
    import tex_pkg::*;

    logic [FIXED_FRAC-1:0] frac;
    logic                  neg;
    logic                  over;

    assign frac = coord_i[FIXED_FRAC-1:0];
    assign neg  = coord_i[31];
    assign over = |coord_i[30:FIXED_FRAC];   // integer part of 1 or more

    always_comb begin
        case (wrap_i)
            WRAP_CLAMP: begin
                if (neg) coord_o = '0;
                else if (over) coord_o = '1;   // largest value below 1
                else coord_o = frac;
            end
            // odd integer intervals run backwards
            WRAP_MIRROR: coord_o = coord_i[FIXED_FRAC] ? ~frac : frac;
            default: coord_o = frac;
        endcase
    end

endmodule

// File: test/tex_unit_chk.sv
`timescale 1ns/1ps

module tex_unit_chk (
    input logic              clk_i,
    input logic              rst_n_i,
    input logic              req_valid_i,
    input logic              req_ready_i,
    input tex_pkg::tex_req_t req_i,
    input logic              mem_rd_i,
    input logic              rsp_valid_i,
    input logic              rsp_ready_i,
    input tex_pkg::tex_rsp_t rsp_i
);
    int unsigned fail_cnt = 0;   // failed assertions so far

    a_req_hold: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        req_valid_i && !req_ready_i |=> req_valid_i && $stable(req_i))
        else begin
            fail_cnt++;
            $error("request dropped or changed while not ready");
        end

    a_rsp_hold: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        rsp_valid_i && !rsp_ready_i |=> rsp_valid_i && $stable(rsp_i))
        else begin
            fail_cnt++;
            $error("response dropped or changed while not ready");
        end

    // outputs settle one clock after reset is seen
    a_reset_quiet: assert property (@(posedge clk_i)
        !rst_n_i |=> !mem_rd_i && !rsp_valid_i && !req_ready_i)
        else begin
            fail_cnt++;
            $error("output active during reset");
        end

endmodule

bind tex_unit_top tex_unit_chk tex_unit_chk_i (
    .clk_i       (clk_i),
    .rst_n_i     (rst_n_i),
    .req_valid_i (req_valid_i),
    .req_ready_i (req_ready_o),
    .req_i       (req_i),
    .mem_rd_i    (mem_rd_o),
    .rsp_valid_i (rsp_valid_o),
    .rsp_ready_i (rsp_ready_i),
    .rsp_i       (rsp_o)
);

// File: test/tex_unit_tb.sv
`timescale 1ns/1ps

module tex_unit_tb;
    import tex_pkg::*;

    localparam int TIMEOUT_CYCLES = 20000;

    logic              clk;
    logic              rst_n;
    logic              cfg_we;
    tex_cfg_e          cfg_sel;
    logic [31:0]       cfg_data;
    logic              req_valid;
    logic              req_ready;
    tex_req_t          req;
    logic              mem_rd;
    logic [ADDR_W-1:0] mem_addr;
    logic [31:0]       mem_data;
    logic              rsp_valid;
    logic              rsp_ready;
    tex_rsp_t          rsp;

    integer            seed;
    int unsigned       cycles = 0;
    int unsigned       rd_count = 0;
    logic              rd_q;
    logic [ADDR_W-1:0] rd_addr_q;
    logic              bp_en;
    string             test_name;
    tex_rsp_t          exp_q[$];

    // copy of the configuration the DUT should hold
    logic [ADDR_W-1:0] base;
    logic [3:0]        lw, lh, ls;
    tex_wrap_e         wrap_u, wrap_v;
    tex_filter_e       filt;

    tex_unit_top tex_unit_top_i (
        .clk_i       (clk),
        .rst_n_i     (rst_n),
        .cfg_we_i    (cfg_we),
        .cfg_sel_i   (cfg_sel),
        .cfg_data_i  (cfg_data),
        .req_valid_i (req_valid),
        .req_ready_o (req_ready),
        .req_i       (req),
        .mem_rd_o    (mem_rd),
        .mem_addr_o  (mem_addr),
        .mem_data_i  (mem_data),
        .rsp_valid_o (rsp_valid),
        .rsp_ready_i (rsp_ready),
        .rsp_o       (rsp)
    );

    initial clk = 1'b0;
    always #4 clk = ~clk;

    task stop_fail;
        $display("TEST RESULT: FAIL");
        $fatal(1, "simulation stopped");
    endtask

    task check(input string name, input logic [31:0] exp, input logic [31:0] act);
        if (exp !== act) begin
            $display("Error: %s expected %h actual %h", name, exp, act);
            stop_fail();
        end
    endtask

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= TIMEOUT_CYCLES) begin
            $display("Timeout: the run did not finish within %0d cycles", TIMEOUT_CYCLES);
            stop_fail();
        end
    end

    // single-port texel memory whose data shows up one cycle after the read strobe
    always @(posedge clk) begin
        rd_q      <= mem_rd;
        rd_addr_q <= mem_addr;
        if (mem_rd) rd_count <= rd_count + 1;
    end

    always @(negedge clk) mem_data = rd_q ? texel_word(rd_addr_q) : 'x;

    function automatic logic [31:0] texel_word(input logic [ADDR_W-1:0] a);
        return 32'(a) * 32'h0101_0101 + 32'h0004_0812;
    endfunction

    function automatic logic [FIXED_FRAC-1:0] wrapped_coord(input tex_wrap_e mode,
                                                            input logic [31:0] c);
        logic signed [31:0] ipart;
        ipart = $signed(c) >>> FIXED_FRAC;   // floor of the coordinate
        if (mode == WRAP_CLAMP && ipart < 0) return '0;
        if (mode == WRAP_CLAMP && ipart > 0) return '1;
        if (mode == WRAP_MIRROR && ipart[0]) return ~c[FIXED_FRAC-1:0];
        return c[FIXED_FRAC-1:0];
    endfunction

    function automatic logic [ADDR_W-1:0] word_addr(input logic [31:0] x, input logic [31:0] y);
        logic [31:0] ofs;
        ofs = (x + (y << lw)) << ls;
        return base + ofs[ADDR_W-1:0];
    endfunction

    function automatic logic [7:0] mix_channel(input int a, input int b, input int w);
        return 8'((a * (256 - w) + b * w) >> 8);
    endfunction

    function automatic logic [31:0] expected_texel(input logic [31:0] u, input logic [31:0] v);
        logic [31:0]           du, dv, x0, x1, y0, y1;
        logic [FIXED_FRAC-1:0] u0, u1, v0, v1, fu, fv;
        logic [31:0]           c00, c10, c01, c11, res;
        logic [7:0]            top, bot;
        du = (filt == FILTER_BILINEAR) ? (FIXED_HALF >> lw) : 32'd0;
        dv = (filt == FILTER_BILINEAR) ? (FIXED_HALF >> lh) : 32'd0;
        u0 = wrapped_coord(wrap_u, u - du);
        u1 = wrapped_coord(wrap_u, u + du);
        v0 = wrapped_coord(wrap_v, v - dv);
        v1 = wrapped_coord(wrap_v, v + dv);
        x0 = 32'(u0) >> (FIXED_FRAC - lw);
        x1 = 32'(u1) >> (FIXED_FRAC - lw);
        y0 = 32'(v0) >> (FIXED_FRAC - lh);
        y1 = 32'(v1) >> (FIXED_FRAC - lh);
        c00 = texel_word(word_addr(x0, y0));
        c10 = texel_word(word_addr(x1, y0));
        c01 = texel_word(word_addr(x0, y1));
        c11 = texel_word(word_addr(x1, y1));
        if (filt == FILTER_POINT) return c00;
        fu = u0 << lw;   // fraction left below x0 with its top aligned
        fv = v0 << lh;
        for (int ch = 0; ch < 4; ch++) begin
            top = mix_channel(c00[ch*8 +: 8], c10[ch*8 +: 8], fu[FIXED_FRAC-1 -: WEIGHT_W]);
            bot = mix_channel(c01[ch*8 +: 8], c11[ch*8 +: 8], fu[FIXED_FRAC-1 -: WEIGHT_W]);
            res[ch*8 +: 8] = mix_channel(top, bot, fv[FIXED_FRAC-1 -: WEIGHT_W]);
        end
        return res;
    endfunction

    function automatic tex_rsp_t expected_rsp(input tex_req_t r);
        tex_rsp_t e;
        e.mask = r.mask;
        e.tag  = r.tag;
        for (int l = 0; l < NUM_LANES; l++) begin
            e.texel[l] = r.mask[l] ? expected_texel(r.u[l], r.v[l]) : 32'd0;
        end
        return e;
    endfunction

    task check_response(input tex_rsp_t act);
        tex_rsp_t exp;
        if (exp_q.size() == 0) begin
            $display("Response with tag %0d arrived with no request outstanding", act.tag);
            stop_fail();
        end else begin
            exp = exp_q.pop_front();
            check({test_name, " tag"}, 32'(exp.tag), 32'(act.tag));
            check({test_name, " mask"}, 32'(exp.mask), 32'(act.mask));
            for (int l = 0; l < NUM_LANES; l++) begin
                check($sformatf("%s lane %0d", test_name, l), exp.texel[l], act.texel[l]);
            end
        end
    endtask

    // ready and capture of responses happen in one process at the falling edge
    always @(negedge clk) begin
        rsp_ready = bp_en ? (($random(seed) & 1) != 0) : 1'b1;
        if (tex_unit_top_i.tex_unit_chk_i.fail_cnt != 0) begin
            $display("A handshake or reset assertion failed in %s", test_name);
            stop_fail();
        end else if (rsp_valid && rsp_ready) begin
            check_response(rsp);
        end
    end

    task write_cfg(input tex_cfg_e sel, input logic [31:0] data);
        cfg_we   = 1'b1;
        cfg_sel  = sel;
        cfg_data = data;
        @(negedge clk);
        cfg_we = 1'b0;
    endtask

    task set_base(input logic [ADDR_W-1:0] b);
        write_cfg(CFG_BASE, 32'(b));
        base = b;
    endtask

    task set_dims(input logic [3:0] w, input logic [3:0] h, input logic [3:0] s);
        write_cfg(CFG_DIMS, {20'd0, s, h, w});
        lw = w;
        lh = h;
        ls = s;
    endtask

    task set_mode(input tex_wrap_e wu, input tex_wrap_e wv, input tex_filter_e f);
        write_cfg(CFG_MODE, {27'd0, f, wv, wu});
        wrap_u = wu;
        wrap_v = wv;
        filt   = f;
    endtask

    // starts at a falling edge and returns at the falling edge after the transfer
    task send_req(input tex_req_t r);
        req_valid = 1'b1;
        req       = r;
        exp_q.push_back(expected_rsp(r));
        #1;
        while (!req_ready) begin
            @(negedge clk);
            #1;
        end
        @(negedge clk);
        req_valid = 1'b0;
    endtask

    task make_random_req(input logic [3:0] mask, input logic [3:0] tag, output tex_req_t r);
        r.mask = mask;
        r.tag  = tag;
        for (int l = 0; l < NUM_LANES; l++) begin
            r.u[l] = $random(seed) >>> 7;   // roughly -16 to 16 texture widths
            r.v[l] = $random(seed) >>> 7;
        end
    endtask

    task wait_idle;
        while (exp_q.size() != 0) @(negedge clk);
    endtask

    task test_point_repeat;
        tex_req_t r;
        test_name = "point_repeat";
        set_dims(4'd4, 4'd4, 4'd0);
        set_mode(WRAP_REPEAT, WRAP_REPEAT, FILTER_POINT);
        for (int i = 0; i < 4; i++) begin
            make_random_req(4'hf, 4'(i), r);
            send_req(r);
        end
        wait_idle();
    endtask

    task test_clamp_mirror;
        tex_req_t r;
        test_name = "clamp_mirror";
        r.mask = 4'hf;
        r.tag  = 4'h7;
        // -0.25, 1.5, 3.25 and about 0.3 mixed over both axes
        r.u = {32'hfffc_0000, 32'h0018_0000, 32'h0034_0000, 32'h0004_cccc};
        r.v = {32'h0034_0000, 32'hfffc_0000, 32'h0004_cccc, 32'h0018_0000};
        set_mode(WRAP_CLAMP, WRAP_MIRROR, FILTER_POINT);
        send_req(r);
        wait_idle();
        set_mode(WRAP_MIRROR, WRAP_CLAMP, FILTER_POINT);
        send_req(r);
        wait_idle();
        set_mode(WRAP_CLAMP, WRAP_MIRROR, FILTER_BILINEAR);
        send_req(r);
        wait_idle();
    endtask

    task test_bilinear;
        tex_req_t r;
        test_name = "bilinear";
        set_mode(WRAP_REPEAT, WRAP_REPEAT, FILTER_BILINEAR);
        for (int i = 0; i < 4; i++) begin
            make_random_req(4'hf, 4'(i + 4), r);
            send_req(r);
        end
        wait_idle();
    endtask

    task test_lane_mask;
        tex_req_t    r;
        int unsigned start;
        logic [3:0]  masks [0:2];
        test_name = "lane_mask";
        masks = '{4'b0000, 4'b0101, 4'b1000};
        set_mode(WRAP_REPEAT, WRAP_REPEAT, FILTER_BILINEAR);
        for (int i = 0; i < 3; i++) begin
            start = rd_count;
            make_random_req(masks[i], 4'(i + 8), r);
            send_req(r);
            wait_idle();
            check("lane_mask reads", 32'($countones(masks[i]) * 4), rd_count - start);
        end
    endtask

    task test_backpressure;
        tex_req_t r [0:5];
        test_name = "backpressure";
        set_mode(WRAP_REPEAT, WRAP_MIRROR, FILTER_BILINEAR);
        for (int i = 0; i < 6; i++) make_random_req(4'hf, 4'(i + 10), r[i]);
        bp_en = 1'b1;
        for (int i = 0; i < 6; i++) send_req(r[i]);
        wait_idle();
        bp_en = 1'b0;
    endtask

    task test_cfg_change;
        tex_req_t r;
        test_name = "cfg_change";
        set_base(16'h1200);
        set_dims(4'd3, 4'd2, 4'd2);
        set_mode(WRAP_REPEAT, WRAP_REPEAT, FILTER_POINT);
        make_random_req(4'hf, 4'h1, r);
        send_req(r);
        wait_idle();
        set_mode(WRAP_REPEAT, WRAP_REPEAT, FILTER_BILINEAR);
        make_random_req(4'b0110, 4'h2, r);
        send_req(r);
        wait_idle();
    endtask

    initial begin
        seed      = 32'h62f4_0b35;
        rst_n     = 1'b0;
        cfg_we    = 1'b0;
        cfg_sel   = CFG_BASE;
        cfg_data  = '0;
        req_valid = 1'b0;
        req       = '0;
        mem_data  = '0;
        rsp_ready = 1'b0;
        bp_en     = 1'b0;
        base      = '0;
        lw        = '0;
        lh        = '0;
        ls        = '0;
        wrap_u    = WRAP_CLAMP;
        wrap_v    = WRAP_CLAMP;
        filt      = FILTER_POINT;
        test_name = "reset";
        repeat (3) @(negedge clk);
        rst_n = 1'b1;

        test_point_repeat();
        test_clamp_mirror();
        test_bilinear();
        test_lane_mask();
        test_backpressure();
        test_cfg_change();

        repeat (20) @(negedge clk);   // catch late duplicate responses
        if (tex_unit_top_i.tex_unit_chk_i.fail_cnt != 0) begin
            $display("Handshake or reset assertions failed during the run");
            stop_fail();
        end else begin
            $display("TEST RESULT: PASS");
            $finish;
        end
    end

endmodule

// File: verilog.f
rtl/tex_pkg.sv
rtl/tex_wrap.sv
rtl/tex_addr_gen.sv
rtl/tex_mem_sched.sv
rtl/tex_sampler.sv
rtl/tex_ctrl.sv
rtl/tex_unit_top.sv
test/tex_unit_chk.sv
test/tex_unit_tb.sv
